/* files.f */
+incdir+.
mips_isa_pkg.sv
mips_core_pkg.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_fetch.sv
mips_core.sv
mips_tb.sv

/* mips_ref_model.svh */
//******************************
// MIPS ISA reference model
// one instruction per call with its own PC,
// registers, data memory and halt flag
//******************************
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

logic [31:0] m_pc;
logic [31:0] m_regs [32];
logic [31:0] m_dmem [64];
bit          m_halted;
bit          m_st_valid;   // last step stored a word
logic [29:0] m_st_addr;    // word address of that store
logic [31:0] m_st_data;

task automatic model_reset();
   m_pc       = TEXT_START;
   m_halted   = 1'b0;
   m_st_valid = 1'b0;
   for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
   end
   for (int i = 0; i < 64; i++) begin
      m_dmem[i] = fill_word(i);   // same image as the memory after reset
   end
endtask

task automatic model_step();
   logic [29:0] off;
   logic [31:0] w;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] simm;
   logic [31:0] zimm;
   logic [31:0] ea;
   logic [31:0] res;
   logic [31:0] npc;
   logic [31:0] jtarget;
   logic [4:0]  rt;
   logic [4:0]  sh;
   logic [4:0]  dst;
   logic        halt;
   off  = m_pc[31:2] - TEXT_START[31:2];
   w    = (off < 30'd256) ? imem[off[7:0]] : SYSCALL_WORD;   // syscall outside the text
   rt   = w[RT_MSB:RT_LSB];
   sh   = w[SHAMT_MSB:SHAMT_LSB];
   a    = m_regs[w[RS_MSB:RS_LSB]];
   b    = m_regs[rt];
   simm = {{16{w[IMM_MSB]}}, w[IMM_MSB:IMM_LSB]};
   zimm = {16'h0000, w[IMM_MSB:IMM_LSB]};
   ea   = a + simm;
   npc  = m_pc + 32'd4;
   jtarget = {m_pc[31:28], w[TARGET_MSB:TARGET_LSB], 2'b00};
   res  = '0;
   dst  = 5'd0;   // 0 means nothing written
   halt = 1'b0;
   m_st_valid = 1'b0;
   case (w[OP_MSB:OP_LSB])
      OP_SPECIAL: begin
         dst = w[RD_MSB:RD_LSB];
         case (w[FUNCT_MSB:FUNCT_LSB])
            F_SLL:         res = b << sh;
            F_SRL:         res = b >> sh;
            F_SRA:         res = $signed(b) >>> sh;
            F_ADD, F_ADDU: res = a + b;   // no trap
            F_SUB, F_SUBU: res = a - b;
            F_AND:         res = a & b;
            F_OR:          res = a | b;
            F_XOR:         res = a ^ b;
            F_NOR:         res = ~(a | b);
            F_SLT:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F_JR: begin
               dst = 5'd0;
               npc = a;
            end
            F_SYSCALL: begin
               dst  = 5'd0;
               halt = (m_regs[REG_V0] == SYSCALL_EXIT);   // otherwise a no-op
            end
            default: halt = 1'b1;   // reserved funct
         endcase
      end
      OP_J:      npc = jtarget;
      OP_JAL: begin
         npc = jtarget;
         dst = REG_RA;
         res = m_pc + 32'd8;
      end
      OP_BEQ:    npc = (a == b) ? npc + (simm << 2) : npc;
      OP_BNE:    npc = (a != b) ? npc + (simm << 2) : npc;
      OP_ADDIU:  {dst, res} = {rt, ea};
      OP_ANDI:   {dst, res} = {rt, a & zimm};   // logic immediates zero extend
      OP_ORI:    {dst, res} = {rt, a | zimm};
      OP_XORI:   {dst, res} = {rt, a ^ zimm};
      OP_LUI:    {dst, res} = {rt, w[IMM_MSB:IMM_LSB], 16'h0000};
      OP_LW:     {dst, res} = {rt, m_dmem[ea[7:2]]};
      OP_SW: begin
         m_st_valid      = 1'b1;
         m_st_addr       = ea[31:2];
         m_st_data       = b;
         m_dmem[ea[7:2]] = b;
      end
      default: halt = 1'b1;   // reserved opcode
   endcase
   if (halt) begin
      m_halted = 1'b1;   // pc stays on the halting word
   end else begin
      if (dst != 5'd0) begin
         m_regs[dst] = res;
      end
      m_pc = npc;
   end
endtask

`endif

/* mips_tb.sv */
//******************************
// MIPS core testbench
// random programs run against an ISA model,
// combinational instruction and data memories
//******************************
`timescale 1ns/1ns

module mips_tb
   import mips_isa_pkg::*, mips_core_pkg::*;
();

   localparam logic [31:0] SYSCALL_WORD = {26'd0, F_SYSCALL};

   logic        clk;
   logic        rst_b;
   logic [29:0] inst_addr;
   logic [31:0] inst;
   logic [29:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [31:0] mem_rdata;
   logic        mem_we;
   logic        halted;

   logic [31:0] imem [256];   // text at TEXT_START
   logic [31:0] dmem [64];
   logic [29:0] iw_off;
   integer      seed;
   int          gen_pos;      // next free program word
   logic [31:0] exp_halt;     // where the program has to stop

   `include "mips_ref_model.svh"

   mips_core u_mips_core (
      .clk(clk), .rst_b(rst_b),
      .inst_addr(inst_addr), .inst(inst),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
      .mem_we(mem_we), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign iw_off    = inst_addr - TEXT_START[31:2];
   assign inst      = (iw_off < 30'd256) ? imem[iw_off[7:0]] : SYSCALL_WORD;
   assign mem_rdata = dmem[mem_addr[5:0]];

   // data memory, refilled while reset is held
   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < 64; i++) begin
            dmem[i] <= fill_word(i);
         end
      end else if (mem_we) begin
         dmem[mem_addr[5:0]] <= mem_wdata;
      end
   end

   function automatic logic [31:0] fill_word(input int i);
      return (32'(i) + 32'd1) * 32'h9e37_79b9;   // all address bits matter
   endfunction

   function automatic int urand(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic logic [4:0] rand_reg();
      return 5'(urand(31));   // 0..30, $ra left to jal
   endfunction

   function automatic logic [31:0] addr_of(input int idx);
      return TEXT_START + 32'(idx) * 32'd4;
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] enc_j(input logic [5:0] op, input int idx);
      logic [31:0] a;
      a = addr_of(idx);
      return {op, a[27:2]};
   endfunction

   function automatic logic [31:0] rand_alu();
      logic [5:0] fns [12];
      logic [5:0] iops [5];
      fns  = '{F_SLL, F_SRL, F_SRA, F_ADD, F_ADDU, F_SUB, F_SUBU,
               F_AND, F_OR, F_XOR, F_NOR, F_SLT};
      iops = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      if (urand(2) == 0) begin
         return enc_r(fns[urand(12)], rand_reg(), rand_reg(), rand_reg(), 5'(urand(32)));
      end
      return enc_i(iops[urand(5)], rand_reg(), rand_reg(), 16'($random(seed)));
   endfunction

   task automatic emit(input logic [31:0] word);
      imem[gen_pos] = word;
      gen_pos++;
   endtask

   task automatic emit_fillers(input int n);
      repeat (n) emit(rand_alu());
   endtask

   // every jump or branch lands on a chunk start, so all flow moves forward
   task automatic gen_program(input bit with_resv);
      int kind;
      int skip;
      int resv_at;
      for (int i = 0; i < 256; i++) begin
         imem[i] = SYSCALL_WORD;
      end
      gen_pos  = 0;
      exp_halt = '0;
      resv_at  = with_resv ? 16 + urand(200) : 256;
      while (gen_pos < 244) begin
         kind = urand(16);
         skip = 1 + urand(3);
         if (gen_pos >= resv_at && exp_halt == '0) begin
            exp_halt = addr_of(gen_pos);
            emit({6'h3f, 26'($random(seed))});   // opcode 0x3f is unused
         end else begin
            case (kind)
               7:  emit(enc_i(OP_LW, 5'd0, rand_reg(), 16'(urand(64) * 4)));
               8:  emit(enc_i(OP_SW, 5'd0, rand_reg(), 16'(urand(64) * 4)));
               9: begin
                  emit(enc_i(urand(2) ? OP_BNE : OP_BEQ, rand_reg(), rand_reg(), 16'(skip)));
                  emit_fillers(skip);
               end
               10: begin
                  emit(enc_j(OP_J, gen_pos + 1 + skip));
                  emit_fillers(skip);
               end
               11: begin
                  emit(enc_j(OP_JAL, gen_pos + 3));   // call the jr two words on
                  emit_fillers(1);                    // skipped, link is pc + 8
                  emit(enc_j(OP_J, gen_pos + 2));     // after return, hop over the jr
                  emit(enc_r(F_JR, REG_RA, 5'd0, 5'd0, 5'd0));
               end
               12: begin
                  emit(enc_i(OP_ORI, 5'd0, REG_V0, 16'(urand(10))));   // never the exit code
                  emit(SYSCALL_WORD);
               end
               default: emit(rand_alu());
            endcase
         end
      end
      emit(enc_i(OP_ORI, 5'd0, REG_V0, 16'(SYSCALL_EXIT)));
      if (exp_halt == '0) begin
         exp_halt = addr_of(gen_pos);
      end
      emit(SYSCALL_WORD);
   endtask

   task automatic fail_run();
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
         fail_run();
      end
   endtask

   // one model step per cycle until the core halts
   task automatic run_to_halt(input int max_cycles);
      int cycles;
      cycles = 0;
      while (halted !== 1'b1) begin
         if (cycles >= max_cycles) begin
            $display("timeout: core did not halt within %0d cycles", max_cycles);
            fail_run();
         end
         check_value("halted", halted, m_halted);
         check_value("inst_addr", inst_addr, m_pc[31:2]);
         model_step();
         check_value("mem_we", mem_we, m_st_valid);
         if (m_st_valid) begin
            check_value("mem_addr", mem_addr, m_st_addr);
            check_value("mem_wdata", mem_wdata, m_st_data);
         end
         @(negedge clk);
         cycles++;
      end
      check_value("halted", halted, m_halted);
      check_value("inst_addr", inst_addr, m_pc[31:2]);
   endtask

   initial begin
      seed  = 32'h905f2fa0;
      rst_b = 1'b0;
      for (int run = 0; run < 2; run++) begin
         if (run > 0) begin
            @(posedge clk);
            #2 rst_b = 1'b0;
         end
         gen_program(run == 1);   // second program hits a reserved word
         model_reset();
         repeat (8) @(posedge clk);
         #2 rst_b = 1'b1;
         @(negedge clk);
         check_value("inst_addr", inst_addr, TEXT_START[31:2]);
         check_value("halted", halted, 1'b0);
         run_to_halt(1000);
         check_value("halt address", {inst_addr, 2'b00}, exp_halt);
         // frozen and silent after the halt
         repeat (10) begin
            @(negedge clk);
            check_value("halted", halted, 1'b1);
            check_value("inst_addr", inst_addr, m_pc[31:2]);
            check_value("mem_we", mem_we, 1'b0);
         end
         for (int i = 0; i < 64; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], m_dmem[i]);
         end
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* mips_core.sv */
//******************************
// MIPS single-cycle core
// field split, operand/writeback muxes,
// halt state and memory port drive
//******************************
`timescale 1ns/1ns

module mips_core
   import mips_isa_pkg::*, mips_core_pkg::*;
(
   input  logic        clk,
   input  logic        rst_b,
   output logic [29:0] inst_addr,   // word address
   input  logic [31:0] inst,
   output logic [29:0] mem_addr,    // word address
   output logic [31:0] mem_wdata,
   input  logic [31:0] mem_rdata,
   output logic        mem_we,
   output logic        halted
);

   opcode_t     op;
   funct_t      funct;
   logic [4:0]  rs_field;
   logic [4:0]  rt_field;
   logic [4:0]  rd_field;
   logic [4:0]  shamt;
   logic [15:0] imm;
   logic [25:0] target;
   logic        is_syscall;
   logic [4:0]  rs_addr;
   logic        rs_is_exit;

   alu_op_t     alu_op;
   logic        alu_src_imm;
   logic        imm_signed;
   logic        reg_dst_rd;
   logic        dec_reg_we;
   logic        dec_mem_we;
   wb_sel_t     wb_sel;
   pc_sel_t     pc_sel;
   logic        branch_ne;
   logic        halt_req;

   logic [31:0] pc;
   logic [31:0] pc_plus8;
   logic [31:0] rs_data;
   logic [31:0] rt_data;
   logic [31:0] imm_ext;
   logic [31:0] alu_b;
   logic [31:0] alu_result;
   logic        alu_zero;
   logic        take_branch;
   logic [4:0]  wr_addr;
   logic [31:0] wr_data;
   logic        reg_we;

   // instruction fields
   assign op       = opcode_t'(inst[OP_MSB:OP_LSB]);
   assign funct    = funct_t'(inst[FUNCT_MSB:FUNCT_LSB]);
   assign rs_field = inst[RS_MSB:RS_LSB];
   assign rt_field = inst[RT_MSB:RT_LSB];
   assign rd_field = inst[RD_MSB:RD_LSB];
   assign shamt    = inst[SHAMT_MSB:SHAMT_LSB];
   assign imm      = inst[IMM_MSB:IMM_LSB];
   assign target   = inst[TARGET_MSB:TARGET_LSB];

   // syscall borrows the rs read port to look at $v0
   assign is_syscall = (op == OP_SPECIAL) && (funct == F_SYSCALL);
   assign rs_addr    = is_syscall ? REG_V0 : rs_field;
   assign rs_is_exit = (rs_data == SYSCALL_EXIT);

   mips_decode u_decode (
      .op(op), .funct(funct), .rs_is_exit(rs_is_exit),
      .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_signed(imm_signed),
      .reg_dst_rd(reg_dst_rd), .reg_we(dec_reg_we), .mem_we(dec_mem_we),
      .wb_sel(wb_sel), .pc_sel(pc_sel), .branch_ne(branch_ne), .halt_req(halt_req)
   );

   mips_regfile u_regfile (
      .clk(clk), .rst_b(rst_b),
      .rs_addr(rs_addr), .rt_addr(rt_field),
      .wr_addr(wr_addr), .wr_data(wr_data), .wr_en(reg_we),
      .rs_data(rs_data), .rt_data(rt_data)
   );

   // sign extend for addiu/lw/sw, zero extend for logic immediates
   assign imm_ext = imm_signed ? {{16{imm[15]}}, imm} : {16'h0000, imm};
   assign alu_b   = alu_src_imm ? imm_ext : rt_data;

   mips_alu u_alu (
      .alu_op(alu_op), .op_a(rs_data), .op_b(alu_b), .shamt(shamt),
      .result(alu_result), .zero(alu_zero)
   );

   assign take_branch = branch_ne ? !alu_zero : alu_zero;

   mips_fetch u_fetch (
      .clk(clk), .rst_b(rst_b), .halt(halt_req || halted),
      .pc_sel(pc_sel), .take_branch(take_branch),
      .imm(imm), .target(target), .rs_data(rs_data), .pc(pc)
   );

   assign pc_plus8 = pc + 32'd8;   // link skips the delay-slot position

   // writeback
   always_comb begin
      if (wb_sel == WB_LINK) begin
         wr_addr = REG_RA;
      end else begin
         wr_addr = reg_dst_rd ? rd_field : rt_field;
      end
      case (wb_sel)
         WB_MEM:  wr_data = mem_rdata;
         WB_LINK: wr_data = pc_plus8;
         default: wr_data = alu_result;
      endcase
   end

   // sticky until reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (halt_req) begin
         halted <= 1'b1;
      end
   end

   assign reg_we    = dec_reg_we && !halted;
   assign mem_we    = dec_mem_we && !halted;
   assign mem_addr  = alu_result[31:2];
   assign mem_wdata = rt_data;
   assign inst_addr = pc[31:2];

   // once halted the core is frozen and silent
   a_halt_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> (halted && !mem_we && $stable(inst_addr)));

endmodule

/* mips_fetch.sv */
//******************************
// MIPS fetch unit
// PC register and next-PC select,
// frozen while the core is halting
//******************************
`timescale 1ns/1ns

module mips_fetch
   import mips_core_pkg::*;
(
   input  logic        clk,
   input  logic        rst_b,
   input  logic        halt,
   input  pc_sel_t     pc_sel,
   input  logic        take_branch,
   input  logic [15:0] imm,       // branch offset in words
   input  logic [25:0] target,    // jump target in words
   input  logic [31:0] rs_data,   // jr destination
   output logic [31:0] pc
);

   logic [31:0] pc_plus4;
   logic [31:0] br_target;
   logic [31:0] j_target;
   logic [31:0] next_pc;

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};   // signed word offset
   assign j_target  = {pc[31:28], target, 2'b00};               // stays in the 256MB region

   always_comb begin
      case (pc_sel)
         PC_BRANCH: next_pc = take_branch ? br_target : pc_plus4;
         PC_REG:    next_pc = rs_data;
         PC_JUMP:   next_pc = j_target;
         default:   next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= TEXT_START;
      end else if (!halt) begin
         pc <= next_pc;   // one instruction per edge
      end
   end

   // jr to an odd address would break word fetch
   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_b)
      pc[1:0] == 2'b00);

endmodule

/* mips_alu.sv */
//******************************
// MIPS ALU
// add/sub, logic, signed slt, immediate
// shifts on op_b and lui
//******************************
`timescale 1ns/1ns

module mips_alu
   import mips_core_pkg::*;
(
   input  alu_op_t     alu_op,
   input  logic [31:0] op_a,
   input  logic [31:0] op_b,
   input  logic [4:0]  shamt,
   output logic [31:0] result,
   output logic        zero
);

   always_comb begin
      case (alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_NOR: result = ~(op_a | op_b);
         ALU_SLT: begin
            // two's complement compare
            result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         end
         ALU_SLL: result = op_b << shamt;    // rt << sa
         ALU_SRL: result = op_b >> shamt;
         ALU_SRA: result = $unsigned($signed(op_b) >>> shamt);   // keeps sign
         ALU_LUI: result = {op_b[15:0], 16'h0000};
         default: result = 32'd0;
      endcase
   end

   // beq/bne run a subtract, equal when zero
   assign zero = (result == 32'd0);

endmodule

/* mips_regfile.sv */
//******************************
// MIPS register file
// 2 async reads, 1 write at the clock edge,
// $zero reads 0
//******************************
`timescale 1ns/1ns

module mips_regfile (
   input  logic        clk,
   input  logic        rst_b,
   input  logic [4:0]  rs_addr,
   input  logic [4:0]  rt_addr,
   input  logic [4:0]  wr_addr,
   input  logic [31:0] wr_data,
   input  logic        wr_en,
   output logic [31:0] rs_data,
   output logic [31:0] rt_data
);

   logic [31:0] regs [1:31];   // no storage for $zero

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != 5'd0)) begin
         regs[wr_addr] <= wr_data;   // writes to $zero dropped
      end
   end

   // reads see the value before this edge's write
   assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
   assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

/* mips_decode.sv */
//******************************
// MIPS control decoder
// opcode/funct to datapath controls,
// reserved instructions and exit syscall halt
//******************************
`timescale 1ns/1ns

module mips_decode
   import mips_isa_pkg::*, mips_core_pkg::*;
(
   input  opcode_t op,
   input  funct_t  funct,
   input  logic    rs_is_exit,    // $v0 == exit code
   output alu_op_t alu_op,
   output logic    alu_src_imm,
   output logic    imm_signed,
   output logic    reg_dst_rd,
   output logic    reg_we,
   output logic    mem_we,
   output wb_sel_t wb_sel,
   output pc_sel_t pc_sel,
   output logic    branch_ne,
   output logic    halt_req
);

   always_comb begin
      // defaults describe a no-op
      alu_op      = ALU_ADD;
      alu_src_imm = 1'b0;
      imm_signed  = 1'b0;
      reg_dst_rd  = 1'b0;
      reg_we      = 1'b0;
      mem_we      = 1'b0;
      wb_sel      = WB_ALU;
      pc_sel      = PC_SEQ;
      branch_ne   = 1'b0;
      halt_req    = 1'b0;

      case (op)
         OP_SPECIAL: begin
            reg_dst_rd = 1'b1;   // R-type writes rd
            reg_we     = 1'b1;
            case (funct)
               F_SLL:          alu_op = ALU_SLL;
               F_SRL:          alu_op = ALU_SRL;
               F_SRA:          alu_op = ALU_SRA;
               F_ADD, F_ADDU:  alu_op = ALU_ADD;
               F_SUB, F_SUBU:  alu_op = ALU_SUB;
               F_AND:          alu_op = ALU_AND;
               F_OR:           alu_op = ALU_OR;
               F_XOR:          alu_op = ALU_XOR;
               F_NOR:          alu_op = ALU_NOR;
               F_SLT:          alu_op = ALU_SLT;
               F_JR: begin
                  reg_we = 1'b0;
                  pc_sel = PC_REG;
               end
               F_SYSCALL: begin
                  reg_we   = 1'b0;         // no-op unless exit
                  halt_req = rs_is_exit;
               end
               default: halt_req = 1'b1;   // reserved funct
            endcase
         end
         OP_J: pc_sel = PC_JUMP;
         OP_JAL: begin
            pc_sel = PC_JUMP;
            reg_we = 1'b1;
            wb_sel = WB_LINK;   // core picks $ra
         end
         OP_BEQ, OP_BNE: begin
            alu_op    = ALU_SUB;   // zero flag gives equality
            pc_sel    = PC_BRANCH;
            branch_ne = (op == OP_BNE);
         end
         OP_ADDIU: begin
            alu_src_imm = 1'b1;
            imm_signed  = 1'b1;
            reg_we      = 1'b1;
         end
         OP_ANDI: begin
            alu_op      = ALU_AND;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         OP_ORI: begin
            alu_op      = ALU_OR;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         OP_XORI: begin
            alu_op      = ALU_XOR;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         OP_LUI: begin
            alu_op      = ALU_LUI;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         OP_LW: begin
            alu_src_imm = 1'b1;   // base + offset
            imm_signed  = 1'b1;
            reg_we      = 1'b1;
            wb_sel      = WB_MEM;
         end
         OP_SW: begin
            alu_src_imm = 1'b1;
            imm_signed  = 1'b1;
            mem_we      = 1'b1;
         end
         default: halt_req = 1'b1;   // reserved opcode
      endcase

      // halting instruction leaves no state behind
      if (halt_req) begin
         reg_we = 1'b0;
         mem_we = 1'b0;
      end
   end

   // load and store never share an instruction
   a_we_excl: assert final (!(reg_we && mem_we));

endmodule

/* mips_core_pkg.sv */
//******************************
// MIPS core control types
// ALU ops, next-PC and writeback selects,
// reset PC and fixed register numbers
//******************************

package mips_core_pkg;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,   // signed
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI    // op_b low half to upper half
   } alu_op_t;

   // next PC source
   typedef enum logic [1:0] {
      PC_SEQ,      // pc + 4
      PC_BRANCH,   // conditional, needs take_branch
      PC_REG,      // jr
      PC_JUMP      // j / jal
   } pc_sel_t;

   // register writeback source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_LINK    // pc + 8 into $ra
   } wb_sel_t;

   localparam logic [31:0] TEXT_START = 32'h0040_0000;
   localparam logic [4:0]  REG_RA     = 5'd31;
   localparam logic [4:0]  REG_V0     = 5'd2;

endpackage

/* mips_isa_pkg.sv */
//******************************
// MIPS ISA encodings
// primary opcodes, SPECIAL funct codes and
// the bit positions of the instruction fields
//******************************

package mips_isa_pkg;

   // primary opcode, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,   // R-type, decoded by funct
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_t;

   // SPECIAL funct, inst[5:0]
   typedef enum logic [5:0] {
      F_SLL     = 6'h00,
      F_SRL     = 6'h02,
      F_SRA     = 6'h03,
      F_JR      = 6'h08,
      F_SYSCALL = 6'h0c,
      F_ADD     = 6'h20,   // no overflow trap here
      F_ADDU    = 6'h21,
      F_SUB     = 6'h22,   // same, acts as subu
      F_SUBU    = 6'h23,
      F_AND     = 6'h24,
      F_OR      = 6'h25,
      F_XOR     = 6'h26,
      F_NOR     = 6'h27,
      F_SLT     = 6'h2a
   } funct_t;

   // field positions
   localparam int OP_MSB     = 31;
   localparam int OP_LSB     = 26;
   localparam int RS_MSB     = 25;
   localparam int RS_LSB     = 21;
   localparam int RT_MSB     = 20;
   localparam int RT_LSB     = 16;
   localparam int RD_MSB     = 15;
   localparam int RD_LSB     = 11;
   localparam int SHAMT_MSB  = 10;
   localparam int SHAMT_LSB  = 6;
   localparam int FUNCT_MSB  = 5;
   localparam int FUNCT_LSB  = 0;
   localparam int IMM_MSB    = 15;
   localparam int IMM_LSB    = 0;
   localparam int TARGET_MSB = 25;
   localparam int TARGET_LSB = 0;

   localparam logic [31:0] SYSCALL_EXIT = 32'd10;   // $v0 value for exit

endpackage
